//--- rtl/compute_tile_dm.sv
/*
 * Compute tile bus for distributed memory, one Wishbone classic master.
 * Map is DM 0x0-0x7fffffff, UART 0x90000000-f, NA 0xe, boot ROM 0xf.
 * The NA window leaves the tile on ext_req_o. Other addresses get err.
 * IRQ bit 2 is the UART. All other bits are zero.
 */
`timescale 1ns/1ps

module compute_tile_dm
   import tile_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n_i,
   input  wb_req_t     wb_req_i,
   output wb_rsp_t     wb_rsp_o,
   output wb_req_t     ext_req_o,
   input  wb_rsp_t     ext_rsp_i,
   output logic [31:0] irq_o
);

   wb_req_t      dm_req, rom_req, uart_req;
   wb_rsp_t      dm_rsp, rom_rsp, uart_rsp;
   tile_target_e target;

   tile_addr_decode u_decode (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .req_i     (wb_req_i),
      .dm_req_o  (dm_req),
      .rom_req_o (rom_req),
      .uart_req_o(uart_req),
      .ext_req_o (ext_req_o),
      .target_o  (target)
   );

   tile_dm_ram u_dm (.clk(clk), .rst_n_i(rst_n_i), .req_i(dm_req), .rsp_o(dm_rsp));

   tile_bootrom u_bootrom (.clk(clk), .rst_n_i(rst_n_i), .req_i(rom_req), .rsp_o(rom_rsp));

   tile_uart_regs u_uart (
      .clk    (clk),
      .rst_n_i(rst_n_i),
      .req_i  (uart_req),
      .rsp_o  (uart_rsp),
      .irq_o  (irq_o)
   );

   tile_bus_result u_result (
      .clk       (clk),
      .rst_n_i   (rst_n_i),
      .target_i  (target),
      .dm_rsp_i  (dm_rsp),
      .rom_rsp_i (rom_rsp),
      .uart_rsp_i(uart_rsp),
      .ext_rsp_i (ext_rsp_i),
      .stb_i     (wb_req_i.stb),
      .rsp_o     (wb_rsp_o)
   );

endmodule

//--- rtl/tile_addr_decode.sv
/*
 * Address decoder of the tile bus. Purely combinational.
 * Only the selected target sees cyc and stb. Target is picked from adr alone.
 */
`timescale 1ns/1ps

module tile_addr_decode
   import tile_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n_i,
   input  wb_req_t      req_i,
   output wb_req_t      dm_req_o,
   output wb_req_t      rom_req_o,
   output wb_req_t      uart_req_o,
   output wb_req_t      ext_req_o,
   output tile_target_e target_o
);

   tile_addr_u adr_u;
   wb_req_t    idle_req;

   assign adr_u = req_i.adr;

   always_comb begin
      if (!adr_u.rgn.region[3]) begin
         target_o = TGT_DM;                   // 0x0000_0000 to 0x7fff_ffff
      end else if (adr_u.rgn.region == REGION_BOOT) begin
         target_o = TGT_ROM;
      end else if (adr_u.rgn.region == REGION_NA) begin
         target_o = TGT_EXT;                  // Network adapter window
      end else if (adr_u.regv.base == UART_BASE) begin
         target_o = TGT_UART;                 // 16 byte register slot
      end else begin
         target_o = TGT_NONE;
      end
   end

   // Address and data still fan out to every target
   always_comb begin
      idle_req     = req_i;
      idle_req.cyc = 1'b0;
      idle_req.stb = 1'b0;
   end

   assign dm_req_o   = (target_o == TGT_DM)   ? req_i : idle_req;
   assign rom_req_o  = (target_o == TGT_ROM)  ? req_i : idle_req;
   assign uart_req_o = (target_o == TGT_UART) ? req_i : idle_req;
   assign ext_req_o  = (target_o == TGT_EXT)  ? req_i : idle_req;

   a_one_strobe: assert property (@(posedge clk) disable iff (!rst_n_i)
      $onehot0({dm_req_o.stb, rom_req_o.stb, uart_req_o.stb, ext_req_o.stb}))
      else $error("more than one target strobed");

endmodule

//--- rtl/tile_bootrom.sv
/*
 * Boot ROM slave. Word k of the table reads ROM_NOP_BASE + k.
 * Words past the table read zero. Writes end with err.
 */
`timescale 1ns/1ps

module tile_bootrom
   import tile_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n_i,
   input  wb_req_t req_i,
   output wb_rsp_t rsp_o
);

   logic [25:0]       word_idx;
   logic [DATA_W-1:0] rdat;
   logic              ack;
   logic              err;
   logic              access;

   assign word_idx = req_i.adr[27:2];                          // Offset in region
   assign access   = req_i.cyc & req_i.stb & ~(ack | err);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack <= 1'b0;
         err <= 1'b0;
      end else begin
         ack <= access & ~req_i.we;
         err <= access &  req_i.we;     // Read only
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         rdat <= (word_idx < 26'(ROM_WORDS)) ? ROM_NOP_BASE + DATA_W'(word_idx) : '0;
      end
   end

   assign rsp_o.dat = rdat;
   assign rsp_o.ack = ack;
   assign rsp_o.err = err;

endmodule

//--- rtl/tile_bus_result.sv
/*
 * Result stage. Returns the response of the decoded target to the master.
 * Unmapped addresses get a registered err one cycle after the strobe.
 * The external response passes through with no register.
 */
`timescale 1ns/1ps

module tile_bus_result
   import tile_pkg::*;
(
   input  logic         clk,
   input  logic         rst_n_i,
   input  tile_target_e target_i,
   input  wb_rsp_t      dm_rsp_i,
   input  wb_rsp_t      rom_rsp_i,
   input  wb_rsp_t      uart_rsp_i,
   input  wb_rsp_t      ext_rsp_i,
   input  logic         stb_i,
   output wb_rsp_t      rsp_o
);

   logic none_err;

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         none_err <= 1'b0;
      end else begin
         none_err <= stb_i & (target_i == TGT_NONE) & ~none_err;
      end
   end

   always_comb begin
      case (target_i)
         TGT_DM:   rsp_o = dm_rsp_i;
         TGT_ROM:  rsp_o = rom_rsp_i;
         TGT_UART: rsp_o = uart_rsp_i;
         TGT_EXT:  rsp_o = ext_rsp_i;    // Variable latency
         default: begin
            rsp_o     = '0;
            rsp_o.err = none_err;
         end
      endcase
   end

   // Holds for every slave as well as the external port
   a_ack_err_excl: assert property (@(posedge clk) disable iff (!rst_n_i)
      !(rsp_o.ack && rsp_o.err))
      else $error("ack and err raised together");

endmodule

//--- rtl/tile_dm_ram.sv
/*
 * Local data memory slave, 256 words with byte enables.
 * Only adr[9:2] is decoded so the 2 GiB window aliases every 1 KiB.
 * Contents are undefined after reset. Ack one cycle after the strobe.
 */
`timescale 1ns/1ps

module tile_dm_ram
   import tile_pkg::*;
(
   input  logic    clk,
   input  logic    rst_n_i,
   input  wb_req_t req_i,
   output wb_rsp_t rsp_o
);

   logic [DATA_W-1:0]   mem [DM_WORDS];
   logic [DM_IDX_W-1:0] idx;
   logic [DATA_W-1:0]   rdat;
   logic                ack;
   logic                access;

   assign idx    = req_i.adr[DM_IDX_W+1:2];             // Word index
   assign access = req_i.cyc & req_i.stb & ~ack;        // New access only

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         ack <= 1'b0;
      end else begin
         ack <= access;
      end
   end

   always_ff @(posedge clk) begin
      if (access && req_i.we) begin
         for (int b = 0; b < SEL_W; b++) begin
            if (req_i.sel[b]) begin
               mem[idx][8*b +: 8] <= req_i.dat[8*b +: 8];
            end
         end
      end
   end

   // Read data is sampled on the strobe edge
   always_ff @(posedge clk) begin
      if (access && !req_i.we) begin
         rdat <= mem[idx];
      end
   end

   assign rsp_o.dat = rdat;
   assign rsp_o.ack = ack;
   assign rsp_o.err = 1'b0;       // Every offset is valid

endmodule

//--- rtl/tile_pkg.sv
/*
 * Shared memory map, bus types and target codes of the compute tile.
 * Wishbone classic single cycles only. No cab, cti, bte or rty.
 * The data memory is 1 KiB and aliases over its whole 2 GiB window.
 */
package tile_pkg;

   localparam int ADDR_W = 32;
   localparam int DATA_W = 32;
   localparam int SEL_W  = 4;

   localparam int DM_WORDS = 256;  // 1 KiB local data memory
   localparam int DM_IDX_W = 8;

   localparam int          ROM_WORDS    = 8;
   localparam logic [31:0] ROM_NOP_BASE = 32'h1500_0000;  // l.nop pattern

   localparam logic [3:0]  REGION_BOOT = 4'hf;
   localparam logic [3:0]  REGION_NA   = 4'he;

   localparam logic [27:0] UART_BASE     = 28'h900_0000;
   localparam logic [3:0]  UART_TX_OFS   = 4'h0;
   localparam logic [3:0]  UART_STAT_OFS = 4'h4;

   localparam int IRQ_UART_BIT = 2;  // Bits 3 and 4 belonged to the NA

   // Master to slave
   typedef struct packed {
      logic [ADDR_W-1:0] adr;
      logic [DATA_W-1:0] dat;
      logic [SEL_W-1:0]  sel;
      logic              we;
      logic              cyc;
      logic              stb;
   } wb_req_t;

   // Slave to master
   typedef struct packed {
      logic [DATA_W-1:0] dat;
      logic              ack;
      logic              err;
   } wb_rsp_t;

   // One address word seen as a region or as a register slot
   typedef union packed {
      struct packed {
         logic [3:0]  region;
         logic [27:0] rest;
      } rgn;
      struct packed {
         logic [27:0] base;
         logic [3:0]  ofs;
      } regv;
   } tile_addr_u;

   typedef enum logic [2:0] {
      TGT_DM,
      TGT_ROM,
      TGT_UART,
      TGT_EXT,
      TGT_NONE
   } tile_target_e;

endpackage

//--- rtl/tile_uart_regs.sv
/*
 * UART register slave. TX at offset 0, status at offset 4, others err.
 * Status read returns {pending, tx count} and clears pending.
 * Status writes are acked and ignored. irq_o carries pending on bit 2.
 */
`timescale 1ns/1ps

module tile_uart_regs
   import tile_pkg::*;
(
   input  logic        clk,
   input  logic        rst_n_i,
   input  wb_req_t     req_i,
   output wb_rsp_t     rsp_o,
   output logic [31:0] irq_o
);

   tile_addr_u        adr_u;
   logic              tx_sel;
   logic              stat_sel;
   logic              access;
   logic [7:0]        tx_byte;
   logic [7:0]        tx_cnt;   // Wraps at 256
   logic              pending;
   logic [DATA_W-1:0] rdat;
   logic              ack;
   logic              err;

   assign adr_u    = req_i.adr;
   assign tx_sel   = (adr_u.regv.ofs == UART_TX_OFS);
   assign stat_sel = (adr_u.regv.ofs == UART_STAT_OFS);
   assign access   = req_i.cyc & req_i.stb & ~(ack | err);

   always_ff @(posedge clk or negedge rst_n_i) begin
      if (!rst_n_i) begin
         tx_byte <= '0;
         tx_cnt  <= '0;
         pending <= 1'b0;
         ack     <= 1'b0;
         err     <= 1'b0;
      end else begin
         ack <= access & (tx_sel | stat_sel);
         err <= access & ~(tx_sel | stat_sel);
         if (access && tx_sel && req_i.we) begin
            tx_byte <= req_i.dat[7:0];
            tx_cnt  <= tx_cnt + 8'd1;
            pending <= 1'b1;
         end else if (access && stat_sel && !req_i.we) begin
            pending <= 1'b0;                                // Read to clear
         end
      end
   end

   always_ff @(posedge clk) begin
      if (access) begin
         rdat <= stat_sel ? {23'd0, pending, tx_cnt} : {24'd0, tx_byte};
      end
   end

   always_comb begin
      irq_o               = '0;
      irq_o[IRQ_UART_BIT] = pending;
   end

   assign rsp_o.dat = rdat;
   assign rsp_o.ack = ack;
   assign rsp_o.err = err;

endmodule

//--- tb.f
rtl/tile_pkg.sv
rtl/tile_addr_decode.sv
rtl/tile_dm_ram.sv
rtl/tile_bootrom.sv
rtl/tile_uart_regs.sv
rtl/tile_bus_result.sv
rtl/compute_tile_dm.sv
verif/tb_compute_tile_dm.sv

//--- verif/tb_compute_tile_dm.sv
/*
 * Testbench for the compute tile bus. Run from the project root.
 * Accesses come from verif/tile_bus_cases.txt, one classic cycle each.
 * The external slave acks NA accesses with adr XOR key after 0 to 3 cycles.
 */
`timescale 1ns/1ps

module tb_compute_tile_dm
   import tile_pkg::*;
();

   localparam int          TIMEOUT_CYC = 200;
   localparam logic [31:0] EXT_KEY     = 32'hA5A5_A5A5;
   localparam logic [31:0] LFSR_SEED   = 32'h822d_7661;

   logic        clk;
   logic        rst_n_i;
   wb_req_t     wb_req;
   wb_rsp_t     wb_rsp;
   wb_req_t     ext_req;
   wb_rsp_t     ext_rsp;
   logic [31:0] irq;
   logic [31:0] lfsr;
   int          errors;

   compute_tile_dm i_compute_tile_dm (
      .clk      (clk),
      .rst_n_i  (rst_n_i),
      .wb_req_i (wb_req),
      .wb_rsp_o (wb_rsp),
      .ext_req_o(ext_req),
      .ext_rsp_i(ext_rsp),
      .irq_o    (irq)
   );

   initial begin
      clk = 1'b0;
      forever #4 clk = ~clk;                            // 8 ns period
   end

   // Taps 32, 22, 2, 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   // External NA slave, samples on the rising edge and answers on the falling one
   initial begin : ext_slave
      logic        req_seen;
      logic [31:0] req_adr;
      int          wait_left;
      ext_rsp   = '0;
      lfsr      = LFSR_SEED;
      wait_left = -1;
      forever begin
         @(posedge clk);
         req_seen = ext_req.cyc && ext_req.stb && !ext_rsp.ack;
         req_adr  = ext_req.adr;
         @(negedge clk);
         if (ext_rsp.ack) begin
            ext_rsp = '0;                               // One cycle ack
         end else if (req_seen) begin
            if (wait_left < 0) begin
               lfsr      = lfsr_next(lfsr);
               wait_left = lfsr[0];
               lfsr      = lfsr_next(lfsr);
               wait_left = wait_left + 2 * lfsr[0];
            end
            if (wait_left == 0) begin
               ext_rsp.dat = req_adr ^ EXT_KEY;
               ext_rsp.ack = 1'b1;
               wait_left   = -1;
            end else begin
               wait_left = wait_left - 1;
            end
         end
      end
   end

   task automatic run_access(input logic we, input logic [31:0] adr, input logic [31:0] dat,
                             input logic [3:0] sel, output logic got_ack, output logic got_err,
                             output logic [31:0] got_dat, output int cycles);
      logic is_ext;
      is_ext = (adr[31:28] == REGION_NA);
      @(negedge clk);
      wb_req.adr = adr;
      wb_req.dat = dat;
      wb_req.sel = sel;
      wb_req.we  = we;
      wb_req.cyc = 1'b1;
      wb_req.stb = 1'b1;
      cycles  = 0;
      got_ack = 1'b0;
      got_err = 1'b0;
      got_dat = '0;
      while (!(got_ack || got_err) && cycles < TIMEOUT_CYC) begin
         @(posedge clk);
         #2;                                            // Past the registered outputs
         cycles  = cycles + 1;
         got_ack = wb_rsp.ack;
         got_err = wb_rsp.err;
         got_dat = wb_rsp.dat;
         if (is_ext) begin
            if (ext_req.cyc !== 1'b1 || ext_req.stb !== 1'b1) begin
               $display("Mismatch ext_req_o.cyc/stb: got %h/%h expected %h/%h",
                        ext_req.cyc, ext_req.stb, 1'b1, 1'b1);
               errors++;
            end
            if (ext_req.adr !== adr || ext_req.dat !== dat) begin
               $display("Mismatch ext_req_o.adr/dat: got %h/%h expected %h/%h",
                        ext_req.adr, ext_req.dat, adr, dat);
               errors++;
            end
            if (ext_req.sel !== sel || ext_req.we !== we) begin
               $display("Mismatch ext_req_o.sel/we: got %h/%h expected %h/%h",
                        ext_req.sel, ext_req.we, sel, we);
               errors++;
            end
         end else if (ext_req.cyc !== 1'b0 || ext_req.stb !== 1'b0) begin
            $display("Mismatch ext_req_o.cyc/stb: got %h/%h expected %h/%h",
                     ext_req.cyc, ext_req.stb, 1'b0, 1'b0);
            errors++;
         end
         if (got_ack && got_err) begin
            $display("The tile raised ack and err in the same cycle");
            errors++;
         end
      end
      @(negedge clk);
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      @(posedge clk);
      #2;
      if (wb_rsp.ack || wb_rsp.err) begin
         $display("A response was still high one cycle after the access ended");
         errors++;
      end
   endtask

   initial begin : main
      int              fd;
      int              code;
      int              cycles;
      int              n_cases;
      int              n_pass;
      int              errs_before;
      logic            more;
      logic [8*200-1:0] skip_line;
      logic [8*24-1:0] name;
      logic [8*4-1:0]  kind;
      logic            f_we;
      logic [31:0]     f_adr;
      logic [31:0]     f_dat;
      logic [3:0]      f_sel;
      logic [31:0]     exp_dat;
      logic            exp_err;
      logic            exp_pend;
      logic [31:0]     exp_irq;
      logic            got_ack;
      logic            got_err;
      logic [31:0]     got_dat;
      wb_req     = '0;
      wb_req.cyc = 1'b1;                                // DM read strobed through reset
      wb_req.stb = 1'b1;
      rst_n_i    = 1'b0;
      errors     = 0;
      n_cases    = 0;
      n_pass     = 0;
      exp_pend   = 1'b0;
      repeat (2) begin
         @(posedge clk);
         #2;
         if (wb_rsp.ack !== 1'b0 || wb_rsp.err !== 1'b0) begin
            $display("The tile raised ack or err during reset");
            errors++;
         end
      end
      @(negedge clk);
      wb_req.cyc = 1'b0;
      wb_req.stb = 1'b0;
      rst_n_i    = 1'b1;
      if (irq !== 32'd0) begin
         $display("Mismatch irq_o: got %h expected %h", irq, 32'd0);
         errors++;
      end
      fd = $fopen("verif/tile_bus_cases.txt", "r");
      if (fd == 0) begin
         $display("Cannot open the case file verif/tile_bus_cases.txt");
         errors++;
      end else begin
         code = $fgets(skip_line, fd);                  // Two header lines
         code = $fgets(skip_line, fd);
         more = 1'b1;
         while (more) begin
            code = $fscanf(fd, "%s %h %h %h %h %h %s\n",
                           name, f_we, f_adr, f_dat, f_sel, exp_dat, kind);
            if (code != 7) begin
               more = 1'b0;
            end else begin
               errs_before = errors;
               run_access(f_we, f_adr, f_dat, f_sel, got_ack, got_err, got_dat, cycles);
               if (!(got_ack || got_err)) begin
                  $display("Timeout: no ack or err for %0s after %0d cycles", name, cycles);
                  errors++;
               end else begin
                  exp_err = (kind == "err");
                  if (got_err !== exp_err || got_ack !== !exp_err) begin
                     $display("Mismatch wb_rsp_o.ack/err in %0s: got %h/%h expected %h/%h",
                              name, got_ack, got_err, !exp_err, exp_err);
                     errors++;
                  end
                  if (!f_we && !exp_err && got_dat !== exp_dat) begin
                     $display("Mismatch wb_rsp_o.dat in %0s: got %h expected %h",
                              name, got_dat, exp_dat);
                     errors++;
                  end
                  if (f_adr[31:28] != REGION_NA && cycles != 1) begin
                     $display("Mismatch latency in %0s: got %h expected %h", name, cycles, 1);
                     errors++;
                  end
                  if (got_ack && f_we && f_adr == {UART_BASE, UART_TX_OFS}) begin
                     exp_pend = 1'b1;                   // TX write raises the IRQ
                  end
                  if (got_ack && !f_we && f_adr == {UART_BASE, UART_STAT_OFS}) begin
                     exp_pend = 1'b0;
                  end
                  exp_irq               = '0;
                  exp_irq[IRQ_UART_BIT] = exp_pend;
                  if (irq !== exp_irq) begin
                     $display("Mismatch irq_o in %0s: got %h expected %h", name, irq, exp_irq);
                     errors++;
                  end
               end
               n_cases++;
               if (errors == errs_before) begin
                  n_pass++;
                  $display("case %0s passed", name);
               end else begin
                  $display("case %0s failed", name);
               end
            end
         end
         $fclose(fd);
      end
      $display("%0d cases, %0d passed, %0d failed, %0d errors",
               n_cases, n_pass, n_cases - n_pass, errors);
      if (errors == 0 && n_cases > 0) begin
         $display("TEST RESULT: PASS");
      end else begin
         $display("TEST RESULT: FAIL");
      end
      $finish;
   end

endmodule

//--- verif/tile_bus_cases.txt
# name we adr dat sel exp_rdata resp, all numbers in hex
# exp_rdata is checked on acked reads only, resp is ack or err
dm_wr_full 1 00000010 11223344 f 00000000 ack
dm_rd_full 0 00000010 00000000 f 11223344 ack
dm_wr_part 1 00000010 aabbccdd 5 00000000 ack
dm_rd_part 0 00000010 00000000 f 11bb33dd ack
dm_alias_1k 0 00000410 00000000 f 11bb33dd ack
dm_alias_top 0 7ffffc10 00000000 f 11bb33dd ack
dm_wr_alias 1 00000414 cafef00d f 00000000 ack
dm_rd_base 0 00000014 00000000 f cafef00d ack
rom_rd0 0 f0000000 00000000 f 15000000 ack
rom_rd5 0 f0000014 00000000 f 15000005 ack
rom_rd7 0 f000001c 00000000 f 15000007 ack
rom_rd_past 0 f0000020 00000000 f 00000000 ack
rom_wr 1 f0000004 12345678 f 00000000 err
uart_stat0 0 90000004 00000000 f 00000000 ack
uart_tx_a 1 90000000 00000041 1 00000000 ack
uart_tx_rd 0 90000000 00000000 f 00000041 ack
uart_tx_b 1 90000000 0000005a 1 00000000 ack
uart_stat1 0 90000004 00000000 f 00000102 ack
uart_stat2 0 90000004 00000000 f 00000002 ack
uart_bad_ofs 0 90000008 00000000 f 00000000 err
na_rd0 0 e0001000 00000000 f 45a5b5a5 ack
na_wr 1 e0000040 deadbeef f 00000000 ack
na_rd1 0 effffffc 00000000 f 4a5a5a59 ack
na_rd2 0 e1234568 00000000 f 4486e0cd ack
unmap_8 0 80000000 00000000 f 00000000 err
unmap_a 1 a0000000 0badf00d f 00000000 err
unmap_uart_hi 0 90000010 00000000 f 00000000 err
